//--- build.f
logic/vsldu_pkg.sv
logic/vsldu_decode.sv
logic/vsldu_up_shift.sv
logic/vsldu_down_shift.sv
logic/vsldu_result_stage.sv
logic/vsldu_top.sv
verification/vsldu_assert.sv
verification/tb_clock_gen.sv
verification/tb_vsldu.sv

//--- run_sim.sh
#!/bin/sh
# Build the VSLDU testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module tb_vsldu -f build.f -o vsldu_sim \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/vsldu_sim > sim.log 2>&1
cat sim.log

grep -qx "TEST PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- verification/tb_vsldu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector slide unit testbench
// Directed slide, move and timing tests
// against an element-level model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_vsldu;

    localparam int unsigned SEED = 32'hfff0_f2f3;
    // reset, 152 single requests of 2 cycles, one 14-cycle burst
    localparam int TEST_CYCLES = 16 + 2 * (30 + 72 + 18 + 32) + 16;
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

    logic                  clk;
    logic                  arst_n;
    logic                  issue;
    vsldu_pkg::vsldu_req_t req;
    vsldu_pkg::vgroup_t    result;
    logic                  result_valid;

    int          err_cnt;
    int          check_cnt;
    int          cycle_cnt;

    tb_clock_gen i_tb_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    vsldu_top i_vsldu_top (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue        (issue),
        .req          (req),
        .result       (result),
        .result_valid (result_valid)
    );

    function automatic int elem_bits(logic [2:0] sew);
        case (sew)
            3'd1:    return 16;
            3'd2:    return 32;
            default: return 8;
        endcase
    endfunction

    function automatic int group_elem_count(logic [2:0] sew, logic [2:0] lmul);
        int regs;
        case (lmul)
            3'd1:    regs = 2;
            3'd2:    regs = 4;
            default: regs = 1;
        endcase
        return regs * vsldu_pkg::VLEN / elem_bits(sew);
    endfunction

    function automatic logic [31:0] elem_get(vsldu_pkg::vgroup_t v, int idx, int ebits);
        logic [31:0] e;
        e = '0;
        for (int b = 0; b < ebits; b++) begin
            e[b] = v[idx * ebits + b];
        end
        return e;
    endfunction

    function automatic vsldu_pkg::vgroup_t elem_put(vsldu_pkg::vgroup_t v, int idx, int ebits,
                                                    logic [31:0] e);
        vsldu_pkg::vgroup_t r;
        r = v;
        for (int b = 0; b < ebits; b++) begin
            r[idx * ebits + b] = e[b];
        end
        return r;
    endfunction

    // element view of the five operations
    function automatic vsldu_pkg::vgroup_t model_result(vsldu_pkg::vsldu_req_t r);
        int                 ebits;
        int                 n_span;
        int                 n_group;
        int                 off;
        int                 src_idx;
        logic [63:0]        mask;
        logic [31:0]        sc;
        vsldu_pkg::vgroup_t res;
        ebits   = elem_bits(r.sew);
        n_span  = vsldu_pkg::GROUP_BITS / ebits;
        n_group = group_elem_count(r.sew, r.lmul);
        off     = int'(r.scalar[6:0]);
        mask    = (64'd1 << ebits) - 64'd1;
        sc      = r.scalar[31:0] & mask[31:0];
        res     = '0;
        case (r.op)
            vsldu_pkg::OP_SLIDEUP: begin
                if (off >= n_span) begin
                    res = r.src;
                end else begin
                    for (int i = 0; i < n_span; i++) begin
                        src_idx = (i < off) ? i : i - off;  // low part keeps source
                        res = elem_put(res, i, ebits, elem_get(r.src, src_idx, ebits));
                    end
                end
            end
            vsldu_pkg::OP_SLIDEDOWN: begin
                if (off == 0) begin
                    res = r.src;
                end else if (off < n_group) begin
                    for (int i = 0; i < n_group - off; i++) begin
                        res = elem_put(res, i, ebits, elem_get(r.src, i + off, ebits));
                    end
                end
            end
            vsldu_pkg::OP_SLIDE1UP: begin
                res = elem_put(res, 0, ebits, sc);
                for (int i = 1; i < n_span; i++) begin
                    res = elem_put(res, i, ebits, elem_get(r.src, i - 1, ebits));
                end
            end
            vsldu_pkg::OP_SLIDE1DOWN: begin
                for (int i = 0; i < n_group - 1; i++) begin
                    res = elem_put(res, i, ebits, elem_get(r.src, i + 1, ebits));
                end
                res = elem_put(res, n_group - 1, ebits, sc);
            end
            default: res = vsldu_pkg::vgroup_t'(sc);  // move and reserved ops
        endcase
        return res;
    endfunction

    function automatic vsldu_pkg::vsldu_req_t make_req(logic [2:0] op, logic [2:0] sew,
                                                       logic [2:0] lmul, logic [6:0] offset);
        vsldu_pkg::vsldu_req_t r;
        r.op   = vsldu_pkg::vsldu_op_e'(op);
        r.sew  = sew;
        r.lmul = lmul;
        for (int w = 0; w < vsldu_pkg::GROUP_BITS / 32; w++) begin
            r.src[w * 32 +: 32] = $urandom();
        end
        for (int w = 0; w < vsldu_pkg::VLEN / 32; w++) begin
            r.scalar[w * 32 +: 32] = $urandom();
        end
        r.scalar[6:0] = offset;
        return r;
    endfunction

    task automatic check_val(input string what, input vsldu_pkg::vgroup_t got,
                             input vsldu_pkg::vgroup_t expected);
        check_cnt++;
        if (got !== expected) begin
            err_cnt++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, expected);
        end
    endtask

    task automatic issue_and_check(input vsldu_pkg::vsldu_req_t r, input string what);
        vsldu_pkg::vgroup_t expected;
        expected = model_result(r);
        @(negedge clk);
        issue = 1'b1;
        req   = r;
        @(negedge clk);
        issue = 1'b0;
        check_val({what, " valid"}, vsldu_pkg::vgroup_t'(result_valid), 512'd1);
        check_val(what, result, expected);
    endtask

    task automatic reset_check();
        repeat (3) @(negedge clk);
        check_val("valid in reset", vsldu_pkg::vgroup_t'(result_valid), '0);
        check_val("result in reset", result, '0);
        wait (arst_n === 1'b1);
        @(negedge clk);
        check_val("valid after reset", vsldu_pkg::vgroup_t'(result_valid), '0);
        check_val("result after reset", result, '0);
    endtask

    task automatic slide_up_cases();
        int n_span;
        int offs[5];
        for (int s = 0; s < 3; s++) begin
            n_span = vsldu_pkg::GROUP_BITS / elem_bits(3'(s));
            offs   = '{0, n_span / 2 - 1, n_span - 1, n_span, 127};  // last two out of range
            foreach (offs[k]) begin
                repeat (2) begin
                    issue_and_check(make_req(3'd0, 3'(s), 3'($urandom_range(0, 7)), 7'(offs[k])),
                                    $sformatf("slideup sew=%0d off=%0d", s, offs[k]));
                end
            end
        end
    endtask

    task automatic slide_down_cases();
        int n_group;
        int offs[6];
        for (int s = 0; s < 3; s++) begin
            for (int m = 0; m < 4; m++) begin
                n_group = group_elem_count(3'(s), 3'(m));
                offs    = '{0, 1, n_group / 2, n_group - 1, n_group, 127};
                foreach (offs[k]) begin
                    issue_and_check(make_req(3'd1, 3'(s), 3'(m), 7'(offs[k])),
                                    $sformatf("slidedown sew=%0d lmul=%0d off=%0d",
                                              s, m, offs[k]));
                end
            end
        end
    endtask

    task automatic slide_one_cases();
        for (int op = 2; op < 4; op++) begin
            for (int s = 0; s < 3; s++) begin
                for (int m = 0; m < 3; m++) begin
                    issue_and_check(make_req(3'(op), 3'(s), 3'(m), 7'($urandom())),
                                    $sformatf("slide1 op=%0d sew=%0d lmul=%0d", op, s, m));
                end
            end
        end
    endtask

    // ops 5..7 and sew 3..7 fall back to move and e8
    task automatic move_and_reserved_cases();
        for (int op = 4; op < 8; op++) begin
            for (int s = 0; s < 8; s++) begin
                issue_and_check(make_req(3'(op), 3'(s), 3'($urandom_range(0, 7)), 7'($urandom())),
                                $sformatf("move op=%0d sew=%0d", op, s));
            end
        end
    endtask

    task automatic back_to_back_run();
        vsldu_pkg::vsldu_req_t reqs[$];
        vsldu_pkg::vgroup_t    exp_q[$];
        for (int k = 0; k < 12; k++) begin
            reqs.push_back(make_req(3'($urandom_range(0, 7)), 3'($urandom_range(0, 7)),
                                    3'($urandom_range(0, 7)), 7'($urandom())));
            exp_q.push_back(model_result(reqs[k]));
        end
        @(negedge clk);
        issue = 1'b1;
        req   = reqs[0];
        for (int k = 1; k <= 12; k++) begin
            @(negedge clk);
            check_val($sformatf("burst %0d valid", k - 1),
                      vsldu_pkg::vgroup_t'(result_valid), 512'd1);
            check_val($sformatf("burst %0d result", k - 1), result, exp_q[k - 1]);
            if (k < 12) begin
                req = reqs[k];
            end else begin
                issue = 1'b0;
            end
        end
        @(negedge clk);  // idle cycle keeps the last result
        check_val("idle valid", vsldu_pkg::vgroup_t'(result_valid), '0);
        check_val("idle result hold", result, exp_q[11]);
    endtask

    initial begin
        issue     = 1'b0;
        req       = '0;
        err_cnt   = 0;
        check_cnt = 0;
        void'($urandom(SEED));
        reset_check();
        slide_up_cases();
        slide_down_cases();
        slide_one_cases();
        move_and_reserved_cases();
        back_to_back_run();
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset
// 8 ns clock, reset low for 8 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);  // release away from the active edge
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/vsldu_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VSLDU assertions
// Valid timing, reset state and the
// upper bits of move results
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module vsldu_assert (
    input logic               clk,
    input logic               arst_n,
    input logic               issue,
    input logic [2:0]         op,
    input vsldu_pkg::vgroup_t result,
    input logic               result_valid
);

    a_valid_after_issue: assert property (
        @(posedge clk) disable iff (!arst_n) issue |=> result_valid
    ) else $error("result_valid missing one cycle after issue");

    a_no_valid_without_issue: assert property (
        @(posedge clk) disable iff (!arst_n) !issue |=> !result_valid
    ) else $error("result_valid high without a preceding issue");

    a_valid_low_in_reset: assert property (
        @(posedge clk) !arst_n |-> !result_valid
    ) else $error("result_valid high during reset");

    // codes 4..7 all give the move result
    a_move_upper_zero: assert property (
        @(posedge clk) disable iff (!arst_n)
        (issue && (op >= 3'd4)) |=> (result[vsldu_pkg::GROUP_BITS-1:32] == '0)
    ) else $error("move result not zero above 32 bits");

endmodule

bind vsldu_top vsldu_assert i_vsldu_assert (
    .clk          (clk),
    .arst_n       (arst_n),
    .issue        (issue),
    .op           (req.op),
    .result       (result),
    .result_valid (result_valid)
);

`default_nettype wire

//--- logic/vsldu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector slide unit top level
// Decode, up and down shifters, and a
// registered result with a valid pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module vsldu_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   issue,
    input  vsldu_pkg::vsldu_req_t  req,
    output vsldu_pkg::vgroup_t     result,
    output logic                   result_valid
);

    vsldu_pkg::slide_ctrl_t ctrl;
    vsldu_pkg::vgroup_t     up_data;
    vsldu_pkg::vgroup_t     down_data;
    logic                   up_insert;
    logic                   down_insert;

    assign up_insert   = (req.op == vsldu_pkg::OP_SLIDE1UP);
    assign down_insert = (req.op == vsldu_pkg::OP_SLIDE1DOWN);

    vsldu_decode i_vsldu_decode (
        .req  (req),
        .ctrl (ctrl)
    );

    vsldu_up_shift i_vsldu_up_shift (
        .src           (req.src),
        .ctrl          (ctrl),
        .insert_scalar (up_insert),
        .dout          (up_data)
    );

    vsldu_down_shift i_vsldu_down_shift (
        .src           (req.src),
        .ctrl          (ctrl),
        .insert_scalar (down_insert),
        .dout          (down_data)
    );

    vsldu_result_stage i_vsldu_result_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue        (issue),
        .op           (req.op),
        .up_data      (up_data),
        .down_data    (down_data),
        .scalar_elem  (ctrl.scalar_elem),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

//--- logic/vsldu_result_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VSLDU result stage
// Picks the result for the operation and
// registers it with a one-cycle valid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module vsldu_result_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  issue,
    input  vsldu_pkg::vsldu_op_e  op,
    input  vsldu_pkg::vgroup_t    up_data,
    input  vsldu_pkg::vgroup_t    down_data,
    input  vsldu_pkg::elem_t      scalar_elem,
    output vsldu_pkg::vgroup_t    result,
    output logic                  result_valid
);

    vsldu_pkg::vgroup_t sel_data;

    always_comb begin
        case (op)
            vsldu_pkg::OP_SLIDEUP,
            vsldu_pkg::OP_SLIDE1UP:   sel_data = up_data;
            vsldu_pkg::OP_SLIDEDOWN,
            vsldu_pkg::OP_SLIDE1DOWN: sel_data = down_data;
            default:                  sel_data = vsldu_pkg::vgroup_t'(scalar_elem);  // vmv
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue;
            if (issue) begin
                result <= sel_data;  // holds when idle
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/vsldu_down_shift.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VSLDU down shifter
// Right shift inside the register group,
// zero fill above, scalar at the group top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module vsldu_down_shift (
    input  vsldu_pkg::vgroup_t     src,
    input  vsldu_pkg::slide_ctrl_t ctrl,
    input  logic                   insert_scalar,
    output vsldu_pkg::vgroup_t     dout
);

    logic [9:0]         group_bits;
    logic [9:0]         shift_bits;
    logic [9:0]         top_pos;
    vsldu_pkg::vgroup_t group_mask;
    vsldu_pkg::vgroup_t kept;
    vsldu_pkg::vgroup_t shifted;
    vsldu_pkg::vgroup_t top_elem;

    assign group_bits = 10'(ctrl.group_regs) * 10'(vsldu_pkg::VLEN);
    assign shift_bits = {ctrl.down_shift, 3'b000};

    // lowest bit of the group's last element
    assign top_pos = group_bits - {4'd0, ctrl.elem_bytes, 3'b000};

    // shift by 512 clears all, so m4 keeps everything
    assign group_mask = ~({vsldu_pkg::GROUP_BITS{1'b1}} << group_bits);

    assign kept     = src & group_mask;
    assign shifted  = kept >> shift_bits;
    assign top_elem = vsldu_pkg::vgroup_t'(ctrl.scalar_elem) << top_pos;

    always_comb begin
        if (ctrl.offset_zero) begin
            dout = src;              // whole span, not just the group
        end else if (ctrl.down_out_of_range) begin
            dout = '0;
        end else if (insert_scalar) begin
            dout = shifted | top_elem;
        end else begin
            dout = shifted;
        end
    end

endmodule

`default_nettype wire

//--- logic/vsldu_up_shift.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VSLDU up shifter
// Left shift over the full 512-bit span
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module vsldu_up_shift (
    input  vsldu_pkg::vgroup_t     src,
    input  vsldu_pkg::slide_ctrl_t ctrl,
    input  logic                   insert_scalar,
    output vsldu_pkg::vgroup_t     dout
);

    logic [9:0]         shift_bits;
    vsldu_pkg::vgroup_t shifted;
    vsldu_pkg::vgroup_t low_mask;
    vsldu_pkg::vgroup_t fill;

    assign shift_bits = {ctrl.up_shift, 3'b000};
    assign shifted    = src << shift_bits;

    // ones over the vacated low bytes
    assign low_mask = ~({vsldu_pkg::GROUP_BITS{1'b1}} << shift_bits);

    assign fill = insert_scalar ? vsldu_pkg::vgroup_t'(ctrl.scalar_elem) : src;

    always_comb begin
        if (ctrl.up_out_of_range) begin
            dout = src;
        end else begin
            dout = (shifted & ~low_mask) | (fill & low_mask);
        end
    end

endmodule

`default_nettype wire

//--- logic/vsldu_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VSLDU decode
// Element and group size, byte shifts,
// range flags and the masked scalar
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module vsldu_decode (
    input  vsldu_pkg::vsldu_req_t  req,
    output vsldu_pkg::slide_ctrl_t ctrl
);

    logic               slide_one;
    vsldu_pkg::offset_t offset;
    logic [1:0]         size_log2;     // log2 of element bytes
    logic [2:0]         group_regs;
    logic [6:0]         group_bytes;
    logic [6:0]         span_elems;
    logic [6:0]         group_elems;
    logic [8:0]         shift_bytes;   // wide enough for 127 * 4

    assign slide_one = (req.op == vsldu_pkg::OP_SLIDE1UP) ||
                       (req.op == vsldu_pkg::OP_SLIDE1DOWN);

    // slide-one ops always move by a single element
    assign offset = slide_one ? vsldu_pkg::offset_t'(1) : req.scalar[6:0];

    always_comb begin
        case (req.sew)
            3'd1:    size_log2 = 2'd1;
            3'd2:    size_log2 = 2'd2;
            default: size_log2 = 2'd0;  // reserved codes act as e8
        endcase
    end

    always_comb begin
        case (req.lmul)
            3'd1:    group_regs = 3'd2;
            3'd2:    group_regs = 3'd4;
            default: group_regs = 3'd1;  // m8 not supported
        endcase
    end

    assign group_bytes = {group_regs, 4'b0000};
    assign span_elems  = 7'(vsldu_pkg::GROUP_BITS / 8) >> size_log2;
    assign group_elems = group_bytes >> size_log2;
    assign shift_bytes = 9'(offset) << size_log2;

    always_comb begin
        ctrl.elem_bytes        = 3'd1 << size_log2;
        ctrl.up_shift          = vsldu_pkg::byte_shift_t'(shift_bytes);
        ctrl.down_shift        = vsldu_pkg::byte_shift_t'(shift_bytes);
        ctrl.group_regs        = group_regs;
        ctrl.up_out_of_range   = (offset >= span_elems);
        ctrl.down_out_of_range = (offset >= group_elems);
        ctrl.offset_zero       = (offset == '0);
        case (size_log2)
            2'd0:    ctrl.scalar_elem = {24'd0, req.scalar[7:0]};
            2'd1:    ctrl.scalar_elem = {16'd0, req.scalar[15:0]};
            default: ctrl.scalar_elem = req.scalar[31:0];
        endcase
    end

endmodule

`default_nettype wire

//--- logic/vsldu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector slide unit package
// Widths, operation codes, request and
// decoded control types shared by the VSLDU
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package vsldu_pkg;

    localparam int VLEN       = 128;
    localparam int GROUP_REGS = 4;
    localparam int GROUP_BITS = VLEN * GROUP_REGS;

    typedef logic [VLEN-1:0]       vreg_t;
    typedef logic [GROUP_BITS-1:0] vgroup_t;
    typedef vreg_t                 scalar_t;      // rs1, low bits only
    typedef logic [6:0]            offset_t;
    typedef logic [6:0]            byte_shift_t;
    typedef logic [2:0]            sew_t;         // 0:e8 1:e16 2:e32
    typedef logic [2:0]            lmul_t;        // 0:m1 1:m2 2:m4
    typedef logic [31:0]           elem_t;        // widest element

    typedef enum logic [2:0] {
        OP_SLIDEUP    = 3'd0,
        OP_SLIDEDOWN  = 3'd1,
        OP_SLIDE1UP   = 3'd2,
        OP_SLIDE1DOWN = 3'd3,
        OP_MV         = 3'd4
    } vsldu_op_e;

    typedef struct packed {
        vsldu_op_e op;
        sew_t      sew;
        lmul_t     lmul;
        vgroup_t   src;        // vs2 group, reg 0 in the low bits
        scalar_t   scalar;
    } vsldu_req_t;

    typedef struct packed {
        logic [2:0]  elem_bytes;
        byte_shift_t up_shift;
        byte_shift_t down_shift;
        logic [2:0]  group_regs;
        logic        up_out_of_range;
        logic        down_out_of_range;
        logic        offset_zero;
        elem_t       scalar_elem;  // zero above element width
    } slide_ctrl_t;

endpackage

`default_nettype wire
